// ==== src/ekf_config.svh ====
`ifndef EKF_CONFIG_SVH
`define EKF_CONFIG_SVH

// width of one signed filter word
`define EKF_DW 32

// landmark index width
`define EKF_ROW_LEN 10

// words read per stage: pose x, y, heading, then landmark x, y
`define EKF_FETCH_WORDS 5

// word index of landmark 0 x, right after the three pose words
`define EKF_LM_BASE 3

// start of the jacobian and innovation area
`define EKF_JAC_BASE 4096

// longest write-back list (update stage)
`define EKF_WB_MAX 10

// write counter width
`define EKF_WB_CNT_W 4

`endif

// ==== src/ekf_pkg.sv ====
`default_nettype none

`include "ekf_config.svh"

package ekf_pkg;

  // stage code from the host
  // 4 and up are never accepted
  typedef enum logic [2:0] {
    STAGE_IDLE = 3'd0,
    STAGE_PRD  = 3'd1,
    STAGE_NEW  = 3'd2,
    STAGE_UPD  = 3'd3
  } stage_e;

  // one signed filter word, arithmetic wraps
  typedef logic signed [`EKF_DW-1:0] data_t;

  // byte address on the host ram port
  typedef logic [31:0] plb_addr_t;

  // landmark index
  typedef logic [`EKF_ROW_LEN-1:0] lm_idx_t;

endpackage

`default_nettype wire

// ==== src/ekf_stage_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module ekf_stage_ctrl (
  input  wire             clk,
  input  wire             sys_rst,
  input  wire             ekf_pkg::stage_e i_stage_val,
  output logic            o_stage_rdy,
  output ekf_pkg::stage_e o_stage,
  output logic            o_fetch_start,
  input  wire             i_fetch_done,
  output logic            o_init_predict,
  output logic            o_init_newlm,
  output logic            o_init_update,
  input  wire             i_done_predict,
  input  wire             i_done_newlm,
  input  wire             i_done_update,
  output logic            o_capture,
  output logic            o_wb_start,
  input  wire             i_wb_done
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FETCH,
    ST_LAUNCH,
    ST_WAIT,
    ST_CAPTURE,
    ST_WB
  } state_e;

  state_e          state_q;
  ekf_pkg::stage_e stage_q;
  logic            wb_start_q;
  logic            accept;
  logic            done_hit;

  // only predict, new landmark and update start a stage
  assign accept = (state_q == ST_IDLE) &&
                  (i_stage_val inside {ekf_pkg::STAGE_PRD, ekf_pkg::STAGE_NEW,
                                       ekf_pkg::STAGE_UPD});

  // done of the stage in flight, others ignored
  always_comb begin
    case (stage_q)
      ekf_pkg::STAGE_PRD: done_hit = i_done_predict;
      ekf_pkg::STAGE_NEW: done_hit = i_done_newlm;
      ekf_pkg::STAGE_UPD: done_hit = i_done_update;
      default:            done_hit = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      state_q    <= ST_IDLE;
      stage_q    <= ekf_pkg::STAGE_IDLE;
      wb_start_q <= 1'b0;
    end else begin
      // write-back starts the cycle after capture
      wb_start_q <= (state_q == ST_CAPTURE);
      case (state_q)
        ST_IDLE: begin
          if (accept) begin
            state_q <= ST_FETCH;
            stage_q <= i_stage_val;
          end
        end
        ST_FETCH: begin
          if (i_fetch_done) begin
            state_q <= ST_LAUNCH;
          end
        end
        // one cycle of init pulse
        ST_LAUNCH: state_q <= ST_WAIT;
        ST_WAIT: begin
          if (done_hit) begin
            state_q <= ST_CAPTURE;
          end
        end
        ST_CAPTURE: state_q <= ST_WB;
        ST_WB: begin
          if (i_wb_done) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  assign o_stage_rdy    = (state_q == ST_IDLE);
  assign o_stage        = stage_q;
  // fetch kicks off in the acceptance cycle itself
  assign o_fetch_start  = accept;
  assign o_init_predict = (state_q == ST_LAUNCH) && (stage_q == ekf_pkg::STAGE_PRD);
  assign o_init_newlm   = (state_q == ST_LAUNCH) && (stage_q == ekf_pkg::STAGE_NEW);
  assign o_init_update  = (state_q == ST_LAUNCH) && (stage_q == ekf_pkg::STAGE_UPD);
  assign o_capture      = (state_q == ST_CAPTURE);
  assign o_wb_start     = wb_start_q;

endmodule

`default_nettype wire

// ==== src/nonlinear_sampler.sv ====
`timescale 1ns/1ps
`default_nettype none

module nonlinear_sampler (
  input  wire             clk,
  input  wire             sys_rst,
  input  wire             i_capture,
  input  wire             ekf_pkg::stage_e i_stage,
  input  wire             ekf_pkg::data_t i_rk,
  input  wire             ekf_pkg::data_t i_phi,
  input  wire             ekf_pkg::data_t i_result_0,
  input  wire             ekf_pkg::data_t i_result_1,
  input  wire             ekf_pkg::data_t i_result_2,
  input  wire             ekf_pkg::data_t i_result_3,
  input  wire             ekf_pkg::data_t i_result_4,
  input  wire             ekf_pkg::data_t i_result_5,
  input  wire             ekf_pkg::data_t i_xk,
  input  wire             ekf_pkg::data_t i_yk,
  input  wire             ekf_pkg::data_t i_xita,
  input  wire             ekf_pkg::data_t i_lkx,
  input  wire             ekf_pkg::data_t i_lky,
  // predict bank
  output ekf_pkg::data_t  o_x_hat,
  output ekf_pkg::data_t  o_y_hat,
  output ekf_pkg::data_t  o_xita_hat,
  output ekf_pkg::data_t  o_fxi_13,
  output ekf_pkg::data_t  o_fxi_23,
  // new landmark bank
  output ekf_pkg::data_t  o_lkx_hat,
  output ekf_pkg::data_t  o_lky_hat,
  output ekf_pkg::data_t  o_gxi_13,
  output ekf_pkg::data_t  o_gxi_23,
  output ekf_pkg::data_t  o_gz_11,
  output ekf_pkg::data_t  o_gz_12,
  output ekf_pkg::data_t  o_gz_21,
  output ekf_pkg::data_t  o_gz_22,
  // update bank
  output ekf_pkg::data_t  o_hxi_11,
  output ekf_pkg::data_t  o_hxi_12,
  output ekf_pkg::data_t  o_hxi_21,
  output ekf_pkg::data_t  o_hxi_22,
  output ekf_pkg::data_t  o_hz_11,
  output ekf_pkg::data_t  o_hz_12,
  output ekf_pkg::data_t  o_hz_21,
  output ekf_pkg::data_t  o_hz_22,
  output ekf_pkg::data_t  o_vt_1,
  output ekf_pkg::data_t  o_vt_2
);

  // results only valid in the done cycle, capture comes one later
  ekf_pkg::data_t r0_q, r1_q, r2_q, r3_q, r4_q, r5_q;

  always_ff @(posedge clk) begin
    r0_q <= i_result_0;
    r1_q <= i_result_1;
    r2_q <= i_result_2;
    r3_q <= i_result_3;
    r4_q <= i_result_4;
    r5_q <= i_result_5;
  end

  // predict: pose estimate plus motion terms
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_x_hat    <= '0;
      o_y_hat    <= '0;
      o_xita_hat <= '0;
      o_fxi_13   <= '0;
      o_fxi_23   <= '0;
    end else if (i_capture && (i_stage == ekf_pkg::STAGE_PRD)) begin
      o_x_hat    <= i_xk + r2_q;
      o_y_hat    <= i_yk + r3_q;
      o_xita_hat <= i_xita + r1_q;
      o_fxi_13   <= -r3_q;
      o_fxi_23   <= r2_q;
    end
  end

  // new landmark, x takes r3 and y takes r2
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_lkx_hat <= '0;
      o_lky_hat <= '0;
      o_gxi_13  <= '0;
      o_gxi_23  <= '0;
      o_gz_11   <= '0;
      o_gz_12   <= '0;
      o_gz_21   <= '0;
      o_gz_22   <= '0;
    end else if (i_capture && (i_stage == ekf_pkg::STAGE_NEW)) begin
      o_lkx_hat <= i_lkx + r3_q;
      o_lky_hat <= i_lky + r2_q;
      o_gxi_13  <= r2_q;
      o_gxi_23  <= r3_q;
      o_gz_11   <= r0_q;
      o_gz_12   <= r2_q;
      o_gz_21   <= r1_q;
      o_gz_22   <= r3_q;
    end
  end

  // update: hz is the negated hxi block
  // innovation wraps at 32 bits
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_hxi_11 <= '0;
      o_hxi_12 <= '0;
      o_hxi_21 <= '0;
      o_hxi_22 <= '0;
      o_hz_11  <= '0;
      o_hz_12  <= '0;
      o_hz_21  <= '0;
      o_hz_22  <= '0;
      o_vt_1   <= '0;
      o_vt_2   <= '0;
    end else if (i_capture && (i_stage == ekf_pkg::STAGE_UPD)) begin
      o_hxi_11 <= -r4_q;
      o_hxi_12 <= -r5_q;
      o_hxi_21 <= r2_q;
      o_hxi_22 <= -r3_q;
      o_hz_11  <= r4_q;
      o_hz_12  <= r5_q;
      o_hz_21  <= -r2_q;
      o_hz_22  <= r3_q;
      o_vt_1   <= i_rk - r0_q;
      o_vt_2   <= i_phi - r1_q;
    end
  end

endmodule

`default_nettype wire

// ==== src/plb_access_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ekf_config.svh"

module plb_access_seq (
  input  wire               clk,
  input  wire               sys_rst,
  input  wire               ekf_pkg::stage_e i_stage,
  input  wire               ekf_pkg::lm_idx_t i_l_k,
  input  wire               i_fetch_start,
  output logic              o_fetch_done,
  input  wire               i_wb_start,
  output logic              o_wb_done,
  input  wire               ekf_pkg::data_t i_x_hat,
  input  wire               ekf_pkg::data_t i_y_hat,
  input  wire               ekf_pkg::data_t i_xita_hat,
  input  wire               ekf_pkg::data_t i_fxi_13,
  input  wire               ekf_pkg::data_t i_fxi_23,
  input  wire               ekf_pkg::data_t i_lkx_hat,
  input  wire               ekf_pkg::data_t i_lky_hat,
  input  wire               ekf_pkg::data_t i_gxi_13,
  input  wire               ekf_pkg::data_t i_gxi_23,
  input  wire               ekf_pkg::data_t i_gz_11,
  input  wire               ekf_pkg::data_t i_gz_12,
  input  wire               ekf_pkg::data_t i_gz_21,
  input  wire               ekf_pkg::data_t i_gz_22,
  input  wire               ekf_pkg::data_t i_hxi_11,
  input  wire               ekf_pkg::data_t i_hxi_12,
  input  wire               ekf_pkg::data_t i_hxi_21,
  input  wire               ekf_pkg::data_t i_hxi_22,
  input  wire               ekf_pkg::data_t i_hz_11,
  input  wire               ekf_pkg::data_t i_hz_12,
  input  wire               ekf_pkg::data_t i_hz_21,
  input  wire               ekf_pkg::data_t i_hz_22,
  input  wire               ekf_pkg::data_t i_vt_1,
  input  wire               ekf_pkg::data_t i_vt_2,
  output ekf_pkg::data_t    o_xk,
  output ekf_pkg::data_t    o_yk,
  output ekf_pkg::data_t    o_xita,
  output ekf_pkg::data_t    o_lkx,
  output ekf_pkg::data_t    o_lky,
  output logic              o_plb_en,
  output logic              o_plb_we,
  output ekf_pkg::plb_addr_t o_plb_addr,
  output ekf_pkg::data_t    o_plb_din,
  input  wire               ekf_pkg::data_t i_plb_dout
);

  localparam int RD_W = $clog2(`EKF_FETCH_WORDS);
  localparam int WC_W = `EKF_WB_CNT_W;
  localparam logic [RD_W-1:0] RD_LAST = RD_W'(`EKF_FETCH_WORDS - 1);
  localparam logic [WC_W-1:0] PRD_WORDS = WC_W'(5);
  localparam logic [WC_W-1:0] NEW_WORDS = WC_W'(8);
  localparam logic [WC_W-1:0] UPD_WORDS = WC_W'(`EKF_WB_MAX);
  localparam logic [31:0] JAC = 32'(`EKF_JAC_BASE);

  logic            rd_active_q;
  logic [RD_W-1:0] rd_idx_q;
  logic            rd_valid_q;
  logic [RD_W-1:0] rd_sel_q;
  logic            wr_active_q;
  logic [WC_W-1:0] wr_idx_q;
  logic [WC_W-1:0] wb_cnt;
  logic [WC_W-1:0] wb_last;
  logic [31:0]     lm_word;
  logic [31:0]     rd_word;
  logic [31:0]     wr_word;
  logic [31:0]     word;
  ekf_pkg::data_t  wr_data;

  // landmark k x coordinate at word 3 + 2k
  assign lm_word = 32'(`EKF_LM_BASE) + 32'({i_l_k, 1'b0});

  // pose words first, then the landmark pair
  assign rd_word = (rd_idx_q < RD_W'(`EKF_LM_BASE)) ? 32'(rd_idx_q)
                 : lm_word + 32'(rd_idx_q) - 32'(`EKF_LM_BASE);

  // read sequencer, one word per cycle after start
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      rd_active_q <= 1'b0;
      rd_idx_q    <= '0;
      rd_valid_q  <= 1'b0;
    end else begin
      rd_valid_q <= rd_active_q;
      if (i_fetch_start) begin
        rd_active_q <= 1'b1;
        rd_idx_q    <= '0;
      end else if (rd_active_q) begin
        if (rd_idx_q == RD_LAST) begin
          rd_active_q <= 1'b0;
        end
        rd_idx_q <= rd_idx_q + 1'b1;
      end
    end
  end

  // ram answers one cycle late
  always_ff @(posedge clk) begin
    rd_sel_q <= rd_idx_q;
    if (rd_valid_q) begin
      case (rd_sel_q)
        RD_W'(0): o_xk   <= i_plb_dout;
        RD_W'(1): o_yk   <= i_plb_dout;
        RD_W'(2): o_xita <= i_plb_dout;
        RD_W'(3): o_lkx  <= i_plb_dout;
        default:  o_lky  <= i_plb_dout;
      endcase
    end
  end

  assign o_fetch_done = rd_valid_q && (rd_sel_q == RD_LAST);

  // write-back list per stage
  always_comb begin
    wb_cnt  = WC_W'(1);
    wr_word = JAC + 32'(wr_idx_q);
    wr_data = '0;
    case (i_stage)
      ekf_pkg::STAGE_PRD: begin
        wb_cnt = PRD_WORDS;
        if (wr_idx_q < WC_W'(3)) begin
          wr_word = 32'(wr_idx_q);
        end else begin
          wr_word = JAC + 32'(wr_idx_q) - 32'd3;
        end
        case (wr_idx_q)
          WC_W'(0): wr_data = i_x_hat;
          WC_W'(1): wr_data = i_y_hat;
          WC_W'(2): wr_data = i_xita_hat;
          WC_W'(3): wr_data = i_fxi_13;
          default:  wr_data = i_fxi_23;
        endcase
      end
      ekf_pkg::STAGE_NEW: begin
        wb_cnt = NEW_WORDS;
        // landmark pair back in place, G block into the jacobian area
        if (wr_idx_q < WC_W'(2)) begin
          wr_word = lm_word + 32'(wr_idx_q);
        end else begin
          wr_word = JAC + 32'(wr_idx_q) - 32'd2;
        end
        case (wr_idx_q)
          WC_W'(0): wr_data = i_lkx_hat;
          WC_W'(1): wr_data = i_lky_hat;
          WC_W'(2): wr_data = i_gxi_13;
          WC_W'(3): wr_data = i_gxi_23;
          WC_W'(4): wr_data = i_gz_11;
          WC_W'(5): wr_data = i_gz_12;
          WC_W'(6): wr_data = i_gz_21;
          default:  wr_data = i_gz_22;
        endcase
      end
      ekf_pkg::STAGE_UPD: begin
        wb_cnt = UPD_WORDS;
        case (wr_idx_q)
          WC_W'(0): wr_data = i_hxi_11;
          WC_W'(1): wr_data = i_hxi_12;
          WC_W'(2): wr_data = i_hxi_21;
          WC_W'(3): wr_data = i_hxi_22;
          WC_W'(4): wr_data = i_hz_11;
          WC_W'(5): wr_data = i_hz_12;
          WC_W'(6): wr_data = i_hz_21;
          WC_W'(7): wr_data = i_hz_22;
          WC_W'(8): wr_data = i_vt_1;
          default:  wr_data = i_vt_2;
        endcase
      end
      default: ;
    endcase
  end

  assign wb_last = wb_cnt - 1'b1;

  // write sequencer, back to back
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      wr_active_q <= 1'b0;
      wr_idx_q    <= '0;
    end else if (i_wb_start) begin
      wr_active_q <= 1'b1;
      wr_idx_q    <= '0;
    end else if (wr_active_q) begin
      if (wr_idx_q == wb_last) begin
        wr_active_q <= 1'b0;
      end
      wr_idx_q <= wr_idx_q + 1'b1;
    end
  end

  // done flags the last write itself
  assign o_wb_done = wr_active_q && (wr_idx_q == wb_last);

  // ram port shared by both sequencers
  assign word       = wr_active_q ? wr_word : rd_word;
  assign o_plb_en   = rd_active_q | wr_active_q;
  assign o_plb_we   = wr_active_q;
  assign o_plb_addr = {word[29:0], 2'b00};
  assign o_plb_din  = wr_data;

endmodule

`default_nettype wire

// ==== src/ekf_frontend_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ekf_frontend_top (
  input  wire                clk,
  input  wire                sys_rst,
  // host stage handshake
  input  wire                ekf_pkg::stage_e i_stage_val,
  output logic               o_stage_rdy,
  input  wire                ekf_pkg::lm_idx_t i_l_k,
  input  wire                ekf_pkg::data_t i_rk,
  input  wire                ekf_pkg::data_t i_phi,
  // host block ram
  output logic               o_plb_en,
  output logic               o_plb_we,
  output ekf_pkg::plb_addr_t o_plb_addr,
  output ekf_pkg::data_t     o_plb_din,
  input  wire                ekf_pkg::data_t i_plb_dout,
  // nonlinear unit
  output logic               o_init_predict,
  output logic               o_init_newlm,
  output logic               o_init_update,
  output ekf_pkg::data_t     o_xk,
  output ekf_pkg::data_t     o_yk,
  output ekf_pkg::data_t     o_xita,
  output ekf_pkg::data_t     o_lkx,
  output ekf_pkg::data_t     o_lky,
  input  wire                i_done_predict,
  input  wire                i_done_newlm,
  input  wire                i_done_update,
  input  wire                ekf_pkg::data_t i_result_0,
  input  wire                ekf_pkg::data_t i_result_1,
  input  wire                ekf_pkg::data_t i_result_2,
  input  wire                ekf_pkg::data_t i_result_3,
  input  wire                ekf_pkg::data_t i_result_4,
  input  wire                ekf_pkg::data_t i_result_5
);

  ekf_pkg::stage_e stage;
  logic            fetch_start;
  logic            fetch_done;
  logic            capture;
  logic            wb_start;
  logic            wb_done;

  // sampled banks toward the write-back
  ekf_pkg::data_t x_hat, y_hat, xita_hat, fxi_13, fxi_23;
  ekf_pkg::data_t lkx_hat, lky_hat, gxi_13, gxi_23;
  ekf_pkg::data_t gz_11, gz_12, gz_21, gz_22;
  ekf_pkg::data_t hxi_11, hxi_12, hxi_21, hxi_22;
  ekf_pkg::data_t hz_11, hz_12, hz_21, hz_22;
  ekf_pkg::data_t vt_1, vt_2;

  ekf_stage_ctrl u_ctrl (
    .clk            (clk),
    .sys_rst        (sys_rst),
    .i_stage_val    (i_stage_val),
    .o_stage_rdy    (o_stage_rdy),
    .o_stage        (stage),
    .o_fetch_start  (fetch_start),
    .i_fetch_done   (fetch_done),
    .o_init_predict (o_init_predict),
    .o_init_newlm   (o_init_newlm),
    .o_init_update  (o_init_update),
    .i_done_predict (i_done_predict),
    .i_done_newlm   (i_done_newlm),
    .i_done_update  (i_done_update),
    .o_capture      (capture),
    .o_wb_start     (wb_start),
    .i_wb_done      (wb_done)
  );

  // pose and landmark come back from the ram sequencer
  nonlinear_sampler u_sampler (
    .clk        (clk),
    .sys_rst    (sys_rst),
    .i_capture  (capture),
    .i_stage    (stage),
    .i_rk       (i_rk),
    .i_phi      (i_phi),
    .i_result_0 (i_result_0),
    .i_result_1 (i_result_1),
    .i_result_2 (i_result_2),
    .i_result_3 (i_result_3),
    .i_result_4 (i_result_4),
    .i_result_5 (i_result_5),
    .i_xk       (o_xk),
    .i_yk       (o_yk),
    .i_xita     (o_xita),
    .i_lkx      (o_lkx),
    .i_lky      (o_lky),
    .o_x_hat    (x_hat),
    .o_y_hat    (y_hat),
    .o_xita_hat (xita_hat),
    .o_fxi_13   (fxi_13),
    .o_fxi_23   (fxi_23),
    .o_lkx_hat  (lkx_hat),
    .o_lky_hat  (lky_hat),
    .o_gxi_13   (gxi_13),
    .o_gxi_23   (gxi_23),
    .o_gz_11    (gz_11),
    .o_gz_12    (gz_12),
    .o_gz_21    (gz_21),
    .o_gz_22    (gz_22),
    .o_hxi_11   (hxi_11),
    .o_hxi_12   (hxi_12),
    .o_hxi_21   (hxi_21),
    .o_hxi_22   (hxi_22),
    .o_hz_11    (hz_11),
    .o_hz_12    (hz_12),
    .o_hz_21    (hz_21),
    .o_hz_22    (hz_22),
    .o_vt_1     (vt_1),
    .o_vt_2     (vt_2)
  );

  plb_access_seq u_plb (
    .clk           (clk),
    .sys_rst       (sys_rst),
    .i_stage       (stage),
    .i_l_k         (i_l_k),
    .i_fetch_start (fetch_start),
    .o_fetch_done  (fetch_done),
    .i_wb_start    (wb_start),
    .o_wb_done     (wb_done),
    .i_x_hat       (x_hat),
    .i_y_hat       (y_hat),
    .i_xita_hat    (xita_hat),
    .i_fxi_13      (fxi_13),
    .i_fxi_23      (fxi_23),
    .i_lkx_hat     (lkx_hat),
    .i_lky_hat     (lky_hat),
    .i_gxi_13      (gxi_13),
    .i_gxi_23      (gxi_23),
    .i_gz_11       (gz_11),
    .i_gz_12       (gz_12),
    .i_gz_21       (gz_21),
    .i_gz_22       (gz_22),
    .i_hxi_11      (hxi_11),
    .i_hxi_12      (hxi_12),
    .i_hxi_21      (hxi_21),
    .i_hxi_22      (hxi_22),
    .i_hz_11       (hz_11),
    .i_hz_12       (hz_12),
    .i_hz_21       (hz_21),
    .i_hz_22       (hz_22),
    .i_vt_1        (vt_1),
    .i_vt_2        (vt_2),
    .o_xk          (o_xk),
    .o_yk          (o_yk),
    .o_xita        (o_xita),
    .o_lkx         (o_lkx),
    .o_lky         (o_lky),
    .o_plb_en      (o_plb_en),
    .o_plb_we      (o_plb_we),
    .o_plb_addr    (o_plb_addr),
    .o_plb_din     (o_plb_din),
    .i_plb_dout    (i_plb_dout)
  );

endmodule

`default_nettype wire

// ==== verification/ekf_frontend_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module ekf_frontend_asserts (
  input wire clk,
  input wire sys_rst,
  input wire i_init_predict,
  input wire i_init_newlm,
  input wire i_init_update,
  input wire i_plb_en,
  input wire i_plb_we,
  input wire i_stage_rdy
);

  logic any_init;

  assign any_init = i_init_predict | i_init_newlm | i_init_update;

  // init lines are single cycle pulses
  a_init_pulse: assert property (@(posedge clk) disable iff (sys_rst)
    any_init |=> !any_init)
    else $error("init pulse held for more than one cycle");

  // at most one init line at a time
  a_init_onehot: assert property (@(posedge clk) disable iff (sys_rst)
    $onehot0({i_init_predict, i_init_newlm, i_init_update}))
    else $error("init pulses overlap");

  a_we_en: assert property (@(posedge clk) disable iff (sys_rst)
    i_plb_we |-> i_plb_en)
    else $error("ram write strobe without enable");

  // ram stays quiet while idle
  a_idle_quiet: assert property (@(posedge clk) disable iff (sys_rst)
    i_stage_rdy |-> !i_plb_en)
    else $error("ram enabled while stage ready");

endmodule

bind ekf_frontend_top ekf_frontend_asserts u_asserts (
  .clk            (clk),
  .sys_rst        (sys_rst),
  .i_init_predict (o_init_predict),
  .i_init_newlm   (o_init_newlm),
  .i_init_update  (o_init_update),
  .i_plb_en       (o_plb_en),
  .i_plb_we       (o_plb_we),
  .i_stage_rdy    (o_stage_rdy)
);

`default_nettype wire

// ==== verification/tb_ekf_frontend.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ekf_config.svh"

module tb_ekf_frontend;

  localparam int RAM_WORDS      = 8192;
  localparam int NUM_STAGES     = 40;
  localparam int TIMEOUT_CYCLES = NUM_STAGES * 40;
  localparam int JAC            = `EKF_JAC_BASE;

  logic               clk;
  logic               sys_rst;
  ekf_pkg::stage_e    i_stage_val;
  logic               o_stage_rdy;
  ekf_pkg::lm_idx_t   i_l_k;
  ekf_pkg::data_t     i_rk, i_phi;
  logic               o_plb_en, o_plb_we;
  ekf_pkg::plb_addr_t o_plb_addr;
  ekf_pkg::data_t     o_plb_din, i_plb_dout;
  logic               o_init_predict, o_init_newlm, o_init_update;
  ekf_pkg::data_t     o_xk, o_yk, o_xita, o_lkx, o_lky;
  logic               i_done_predict, i_done_newlm, i_done_update;
  ekf_pkg::data_t     i_result_0, i_result_1, i_result_2;
  ekf_pkg::data_t     i_result_3, i_result_4, i_result_5;

  // host ram and the model's own copy of it
  logic [31:0] mem    [0:RAM_WORDS-1];
  logic [31:0] shadow [0:RAM_WORDS-1];
  logic [31:0] res    [0:5];
  logic [31:0] rd_val;
  logic        rd_pend;
  integer      seed;
  int          errors, checks, cycle_count;
  int          resp_delay, resp_kind, cur_code, cur_lk, i, n;

  ekf_frontend_top dut0 (
    .clk (clk), .sys_rst (sys_rst),
    .i_stage_val (i_stage_val), .o_stage_rdy (o_stage_rdy),
    .i_l_k (i_l_k), .i_rk (i_rk), .i_phi (i_phi),
    .o_plb_en (o_plb_en), .o_plb_we (o_plb_we), .o_plb_addr (o_plb_addr),
    .o_plb_din (o_plb_din), .i_plb_dout (i_plb_dout),
    .o_init_predict (o_init_predict), .o_init_newlm (o_init_newlm),
    .o_init_update (o_init_update),
    .o_xk (o_xk), .o_yk (o_yk), .o_xita (o_xita), .o_lkx (o_lkx), .o_lky (o_lky),
    .i_done_predict (i_done_predict), .i_done_newlm (i_done_newlm),
    .i_done_update (i_done_update),
    .i_result_0 (i_result_0), .i_result_1 (i_result_1), .i_result_2 (i_result_2),
    .i_result_3 (i_result_3), .i_result_4 (i_result_4), .i_result_5 (i_result_5)
  );

  always #5 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks = checks + 1;
    if (expected !== actual) begin
      errors = errors + 1;
      $display("[FAIL] %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // pose and landmark held toward the nonlinear unit at init time
  task automatic check_fetch();
    int lm;
    lm = `EKF_LM_BASE + 2 * i_l_k;
    check_value("init_stage_kind", cur_code, resp_kind);
    check_value("fetch_xk", mem[0], o_xk);
    check_value("fetch_yk", mem[1], o_yk);
    check_value("fetch_xita", mem[2], o_xita);
    check_value("fetch_lkx", mem[lm], o_lkx);
    check_value("fetch_lky", mem[lm+1], o_lky);
  endtask

  // sampler rules plus write list, applied to the shadow copy
  task automatic apply_model();
    int lm;
    lm = `EKF_LM_BASE + 2 * i_l_k;
    case (resp_kind)
      1: begin
        shadow[0]     = shadow[0] + res[2];
        shadow[1]     = shadow[1] + res[3];
        shadow[2]     = shadow[2] + res[1];
        shadow[JAC]   = -res[3];
        shadow[JAC+1] = res[2];
      end
      2: begin
        shadow[lm]    = shadow[lm] + res[3];
        shadow[lm+1]  = shadow[lm+1] + res[2];
        shadow[JAC]   = res[2];
        shadow[JAC+1] = res[3];
        shadow[JAC+2] = res[0];
        shadow[JAC+3] = res[2];
        shadow[JAC+4] = res[1];
        shadow[JAC+5] = res[3];
      end
      default: begin
        shadow[JAC]   = -res[4];
        shadow[JAC+1] = -res[5];
        shadow[JAC+2] = res[2];
        shadow[JAC+3] = -res[3];
        shadow[JAC+4] = res[4];
        shadow[JAC+5] = res[5];
        shadow[JAC+6] = -res[2];
        shadow[JAC+7] = res[3];
        // innovation, wraps at 32 bits
        shadow[JAC+8] = i_rk - res[0];
        shadow[JAC+9] = i_phi - res[1];
      end
    endcase
  endtask

  task automatic compare_stage(input int num, input int code);
    int j;
    case (code)
      1: begin
        for (j = 0; j < 3; j++)
          check_value($sformatf("stage%0d_predict_pose%0d", num, j), shadow[j], mem[j]);
        for (j = 0; j < 2; j++)
          check_value($sformatf("stage%0d_predict_fxi%0d", num, j),
                      shadow[JAC+j], mem[JAC+j]);
      end
      2: begin
        // whole landmark area, so untouched rows show up too
        for (j = `EKF_LM_BASE; j < `EKF_LM_BASE + 200; j++)
          check_value($sformatf("stage%0d_newlm_lm_word%0d", num, j), shadow[j], mem[j]);
        for (j = 0; j < 6; j++)
          check_value($sformatf("stage%0d_newlm_g%0d", num, j), shadow[JAC+j], mem[JAC+j]);
      end
      default: begin
        for (j = 0; j < 10; j++)
          check_value($sformatf("stage%0d_update_hv%0d", num, j),
                      shadow[JAC+j], mem[JAC+j]);
      end
    endcase
  endtask

  // ram model, requests sampled mid-cycle
  always @(negedge clk) begin
    rd_pend = 1'b0;
    if (o_plb_en) begin
      check_value("plb_addr_range", 32'd0, o_plb_addr >> 15);
      if (o_plb_we) begin
        mem[o_plb_addr[14:2]] = o_plb_din;
      end else begin
        rd_pend = 1'b1;
        rd_val  = mem[o_plb_addr[14:2]];
      end
    end
  end

  // nonlinear unit model, latency 1 to 8 cycles
  always @(negedge clk) begin
    if (!sys_rst && (o_init_predict || o_init_newlm || o_init_update)) begin
      resp_kind = o_init_predict ? 1 : (o_init_newlm ? 2 : 3);
      check_fetch();
      resp_delay = 1 + ({$random(seed)} % 8);
      for (int k = 0; k < 6; k++)
        res[k] = $random(seed);
      apply_model();
    end
  end

  // read data and done pulses, driven just after the edge
  always @(posedge clk) begin
    #1;
    if (rd_pend)
      i_plb_dout = rd_val;
    i_done_predict = 1'b0;
    i_done_newlm   = 1'b0;
    i_done_update  = 1'b0;
    if (resp_delay > 0) begin
      resp_delay = resp_delay - 1;
      if (resp_delay == 0) begin
        i_done_predict = (resp_kind == 1);
        i_done_newlm   = (resp_kind == 2);
        i_done_update  = (resp_kind == 3);
        i_result_0 = res[0];
        i_result_1 = res[1];
        i_result_2 = res[2];
        i_result_3 = res[3];
        i_result_4 = res[4];
        i_result_5 = res[5];
      end
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    clk = 1'b0;
    sys_rst = 1'b1;
    i_stage_val = ekf_pkg::STAGE_IDLE;
    i_l_k = '0;
    i_rk = '0;
    i_phi = '0;
    i_plb_dout = '0;
    i_done_predict = 1'b0;
    i_done_newlm = 1'b0;
    i_done_update = 1'b0;
    i_result_0 = '0;
    i_result_1 = '0;
    i_result_2 = '0;
    i_result_3 = '0;
    i_result_4 = '0;
    i_result_5 = '0;
    seed = 32'hc900;
    errors = 0;
    checks = 0;
    cycle_count = 0;
    resp_delay = 0;
    resp_kind = 0;
    cur_code = 0;
    rd_pend = 1'b0;
    for (i = 0; i < RAM_WORDS; i++) begin
      mem[i]    = $random(seed);
      shadow[i] = mem[i];
    end
    repeat (3) @(posedge clk);
    #1 sys_rst = 1'b0;
    // idle after reset, then codes that must be ignored
    @(negedge clk);
    check_value("reset_rdy", 32'd1, o_stage_rdy);
    check_value("reset_init", 32'd0, {o_init_predict, o_init_newlm, o_init_update});
    check_value("reset_plb_en", 32'd0, o_plb_en);
    for (i = 0; i < 5; i++) begin
      @(posedge clk);
      #1 i_stage_val = ekf_pkg::stage_e'((i == 0) ? 0 : i + 3);
      // a taken code would show one cycle later
      @(posedge clk);
      @(negedge clk);
      check_value($sformatf("ignored_code%0d_rdy", i_stage_val), 32'd1, o_stage_rdy);
      check_value($sformatf("ignored_code%0d_plb_en", i_stage_val), 32'd0, o_plb_en);
    end
    for (n = 0; n < NUM_STAGES; n++) begin
      @(posedge clk);
      #1;
      cur_code    = 1 + ({$random(seed)} % 3);
      cur_lk      = {$random(seed)} % 100;
      i_l_k       = ekf_pkg::lm_idx_t'(cur_lk);
      i_rk        = $random(seed);
      i_phi       = $random(seed);
      i_stage_val = ekf_pkg::stage_e'(cur_code);
      @(posedge clk);
      #1 i_stage_val = ekf_pkg::STAGE_IDLE;
      @(negedge clk);
      while (!o_stage_rdy)
        @(negedge clk);
      compare_stage(n, cur_code);
    end
    // full ram against the shadow copy
    for (i = 0; i < RAM_WORDS; i++)
      check_value($sformatf("ram_word_%0d", i), shadow[i], mem[i]);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+src
src/ekf_pkg.sv
src/ekf_stage_ctrl.sv
src/nonlinear_sampler.sv
src/plb_access_seq.sv
src/ekf_frontend_top.sv
verification/ekf_frontend_asserts.sv
verification/tb_ekf_frontend.sv

// ==== Bender.yml ====
package:
  name: ekf_frontend

export_include_dirs:
  - src

sources:
  - files:
      - src/ekf_pkg.sv
      - src/ekf_stage_ctrl.sv
      - src/nonlinear_sampler.sv
      - src/plb_access_seq.sv
      - src/ekf_frontend_top.sv
  - target: test
    files:
      - verification/ekf_frontend_asserts.sv
      - verification/tb_ekf_frontend.sv
